// File: hdl/tms9900_pkg.sv
package tms9900_pkg;

   typedef logic [0:15] word_t;  // Bit 0 is the MSB
   typedef logic [0:14] addr_t;  // Word address on the bus

   localparam int ST_LGT = 0;
   localparam int ST_AGT = 1;
   localparam int ST_EQ  = 2;
   localparam int ST_C   = 3;
   localparam int ST_OV  = 4;

   localparam addr_t RESET_VECTOR_ADDR = 15'd0;
   localparam int    WS_SHIFT          = 4;  // Register index bits

   localparam logic [0:2] IMM_OP_LI   = 3'b000;
   localparam logic [0:2] IMM_OP_AI   = 3'b001;
   localparam logic [0:2] IMM_OP_ANDI = 3'b010;
   localparam logic [0:2] IMM_OP_ORI  = 3'b011;
   localparam logic [0:2] IMM_OP_CI   = 3'b100;
   localparam logic [0:2] IMM_OP_LWPI = 3'b111;

   // Address register source
   localparam logic [2:0] ADDR_PC       = 3'd0;
   localparam logic [2:0] ADDR_WS_S     = 3'd1;
   localparam logic [2:0] ADDR_WS_D     = 3'd2;
   localparam logic [2:0] ADDR_VEC      = 3'd3;
   localparam logic [2:0] ADDR_VEC_NEXT = 3'd4;

   typedef union packed {
      struct packed {
         logic [0:2]          opcode;
         logic                b;
         logic [0:1]          td;
         logic [0:WS_SHIFT-1] d;
         logic [0:1]          ts;
         logic [0:WS_SHIFT-1] s;
      } fmt_dual;
      struct packed {
         logic [0:7] opcode;
         logic [0:7] disp;
      } fmt_jump;
      struct packed {
         logic [0:7]          opcode;
         logic [0:3]          count;
         logic [0:WS_SHIFT-1] w;
      } fmt_shift;  // Also immediate subcode and register
   } instr_u;

   typedef enum logic [6:0] {
      S_RESET, S_VEC_WP, S_VEC_PC,
      S_IFETCH, S_DECODE, S_ILLEGAL,
      S_IMM_FETCH, S_IMM_READ, S_IMM_EXEC, S_IMM_WB,
      S_JUMP,
      S_TS_READ, S_TD_READ, S_DUAL_EXEC, S_DUAL_WB,
      S_SHIFT_READ, S_SHIFT_STEP, S_SHIFT_WB
   } state_t;

   typedef enum logic [3:0] {
      ALU_PASS, ALU_ADD, ALU_SUB, ALU_CMP, ALU_AND, ALU_OR, ALU_ANDN,
      ALU_SLA, ALU_SRA, ALU_SRL, ALU_SRC
   } alu_op_t;

endpackage

// File: hdl/tms9900_alu.sv
`timescale 1ns/1ns

module tms9900_alu import tms9900_pkg::*; (
   input  alu_op_t    alu_op,
   input  word_t      operand,
   input  word_t      result,
   input  word_t      st,
   input  instr_u     instr,
   output word_t      alu_result,
   output logic [0:4] alu_flags
);

   logic [0:16] sum;  // Carry in bit 0
   logic        carry;
   logic        ovf;
   logic        is_dual;
   word_t       cmp_a;
   word_t       cmp_b;

   // C compares source with destination, CI the register with the immediate
   assign is_dual = (instr.fmt_dual.opcode != 3'b000);
   assign cmp_a = is_dual ? operand : result;
   assign cmp_b = is_dual ? result : operand;

   always_comb begin
      sum = '0;
      alu_result = operand;
      carry = st[ST_C];
      ovf = st[ST_OV];
      case (alu_op)
         ALU_ADD: begin
            sum = {1'b0, result} + {1'b0, operand};
            alu_result = sum[1:16];
            carry = sum[0];
            ovf = (result[0] == operand[0]) && (result[0] != sum[1]);
         end
         ALU_SUB: begin
            sum = {1'b0, result} + {1'b0, ~operand} + 17'd1;
            alu_result = sum[1:16];
            carry = sum[0];  // Set when no borrow
            ovf = (result[0] != operand[0]) && (result[0] != sum[1]);
         end
         ALU_CMP:  alu_result = result;
         ALU_AND:  alu_result = result & operand;
         ALU_OR:   alu_result = result | operand;
         ALU_ANDN: alu_result = result & ~operand;
         ALU_SLA: begin
            {carry, alu_result} = {result, 1'b0};
            ovf = st[ST_OV] || (result[0] != result[1]);  // Sign change on any step
         end
         ALU_SRA: {alu_result, carry} = {result[0], result};
         ALU_SRL: {alu_result, carry} = {1'b0, result};
         ALU_SRC: begin
            alu_result = {result[15], result[0:14]};
            carry = result[15];
         end
         default: alu_result = operand;
      endcase
   end

   always_comb begin
      if (alu_op == ALU_CMP) begin
         alu_flags[ST_LGT] = (cmp_a > cmp_b);
         alu_flags[ST_AGT] = ($signed(cmp_a) > $signed(cmp_b));
         alu_flags[ST_EQ] = (cmp_a == cmp_b);
      end else begin
         alu_flags[ST_LGT] = |alu_result;
         alu_flags[ST_AGT] = !alu_result[0] && (|alu_result);
         alu_flags[ST_EQ] = ~|alu_result;
      end
      alu_flags[ST_C] = carry;
      alu_flags[ST_OV] = ovf;
   end

endmodule

// File: hdl/tms9900_shift_counter.sv
`timescale 1ns/1ns

module tms9900_shift_counter (
   input  logic       clk,
   input  logic       reset,
   input  logic       shift_load,
   input  logic [0:3] count,
   input  logic       shift_step,
   output logic       shift_last
);

   logic [4:0] remaining;  // Steps still to do

   always_ff @(posedge clk) begin
      if (reset)
         remaining <= 5'd0;
      else if (shift_load)
         remaining <= (count == 4'd0) ? 5'd16 : {1'b0, count};  // Zero count means 16
      else if (shift_step && remaining != 5'd0)
         remaining <= remaining - 5'd1;
   end

   assign shift_last = (remaining == 5'd1);

endmodule

// File: hdl/tms9900_regs.sv
`timescale 1ns/1ns

module tms9900_regs import tms9900_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      d_in,
   input  word_t      alu_result,
   input  logic [0:4] alu_flags,
   input  logic       memen,
   input  logic       we,
   input  logic       load_ir,
   input  logic       load_pc,
   input  logic       inc_pc,
   input  logic       load_wp,
   input  logic       load_st_flags,
   input  logic       load_operand,
   input  logic       load_result,
   input  logic [2:0] addr_sel,
   output addr_t      a,
   output word_t      q,
   output logic       dbin,
   output instr_u     instr,
   output word_t      operand,
   output word_t      pc,
   output word_t      st,
   output word_t      wp
);

   word_t               pc_next;
   word_t               wp_next;
   word_t               result;
   word_t               jump_offset;
   logic [0:4]          st_flags;
   logic [0:WS_SHIFT-1] ws_reg;
   addr_t               addr_next;

   assign jump_offset = {{7{instr.fmt_jump.disp[0]}}, instr.fmt_jump.disp, 1'b0};

   // Loads during a bus cycle take read data, otherwise internal values
   always_comb begin
      pc_next = pc;
      if (load_pc)
         pc_next = memen ? d_in : pc + jump_offset;
      else if (inc_pc)
         pc_next = pc + 16'd2;
   end

   assign wp_next = load_wp ? (memen ? d_in : operand) : wp;  // Vector or LWPI
   assign ws_reg = (addr_sel == ADDR_WS_D) ? instr.fmt_dual.d : instr.fmt_dual.s;

   always_comb begin
      case (addr_sel)
         ADDR_WS_S, ADDR_WS_D: addr_next = wp_next[0:14] + addr_t'(ws_reg);
         ADDR_VEC:             addr_next = RESET_VECTOR_ADDR;
         ADDR_VEC_NEXT:        addr_next = RESET_VECTOR_ADDR + 15'd1;
         default:              addr_next = pc_next[0:14];
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         wp <= '0;
         st_flags <= '0;
      end else begin
         pc <= pc_next;
         wp <= wp_next;
         if (load_st_flags) begin
            if (memen)
               st_flags[ST_OV] <= 1'b0;  // SLA operand read
            else
               st_flags <= alu_flags;
         end
      end
   end

   always_ff @(posedge clk) begin
      a <= addr_next;  // Same value again while a bus cycle waits
      if (load_ir)
         instr <= d_in;
      if (load_operand)
         operand <= d_in;
      if (load_result)
         result <= memen ? d_in : alu_result;
   end

   assign st = {st_flags, 11'd0};
   assign q = result;
   assign dbin = memen && !we;

endmodule

// File: hdl/tms9900_control.sv
`timescale 1ns/1ns

module tms9900_control import tms9900_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       ready,
   input  instr_u     instr,
   input  word_t      st,
   input  logic       shift_last,
   output logic       memen,
   output logic       we,
   output logic       iaq,
   output logic [2:0] addr_sel,
   output alu_op_t    alu_op,
   output logic       load_ir,
   output logic       load_pc,
   output logic       inc_pc,
   output logic       load_wp,
   output logic       load_st_flags,
   output logic       load_operand,
   output logic       load_result,
   output logic       shift_load,
   output logic       shift_step
);

   state_t     state;
   state_t     next_state;
   logic       is_dual;
   logic       is_jump;
   logic       is_shift;
   logic       is_imm;
   logic       take_jump;
   logic [0:2] imm_op;

   assign imm_op = instr.fmt_shift.count[0:2];
   assign is_dual = (instr.fmt_dual.opcode[0:1] != 2'b00) && !instr.fmt_dual.b &&
                    (instr.fmt_dual.td == 2'b00) && (instr.fmt_dual.ts == 2'b00);
   assign is_jump = (instr.fmt_jump.opcode[0:3] == 4'b0001) &&
                    (instr.fmt_jump.opcode[4:7] <= 4'b1011);  // No JOP, no CRU bit ops
   assign is_shift = (instr.fmt_shift.opcode[0:5] == 6'b000010);
   assign is_imm = (instr.fmt_shift.opcode == 8'h02) && !instr.fmt_shift.count[3] &&
                   (imm_op != 3'b101) && (imm_op != 3'b110);

   always_comb begin
      case (instr.fmt_jump.opcode[4:7])
         4'b0000: take_jump = 1'b1;                       // JMP
         4'b0001: take_jump = !st[ST_AGT] && !st[ST_EQ];  // JLT
         4'b0010: take_jump = !st[ST_LGT] || st[ST_EQ];   // JLE
         4'b0011: take_jump = st[ST_EQ];                  // JEQ
         4'b0100: take_jump = st[ST_LGT] || st[ST_EQ];    // JHE
         4'b0101: take_jump = st[ST_AGT];                 // JGT
         4'b0110: take_jump = !st[ST_EQ];                 // JNE
         4'b0111: take_jump = !st[ST_C];                  // JNC
         4'b1000: take_jump = st[ST_C];                   // JOC
         4'b1001: take_jump = !st[ST_OV];                 // JNO
         4'b1010: take_jump = !st[ST_LGT] && !st[ST_EQ];  // JL
         4'b1011: take_jump = st[ST_LGT] && !st[ST_EQ];   // JH
         default: take_jump = 1'b0;
      endcase
   end

   always_comb begin
      next_state = state;
      alu_op = ALU_PASS;
      {load_ir, load_pc, inc_pc, load_wp, load_st_flags} = '0;
      {load_operand, load_result, shift_load, shift_step} = '0;
      case (state)
         S_RESET: next_state = S_VEC_WP;
         S_VEC_WP: if (ready) begin
            load_wp = 1'b1;
            next_state = S_VEC_PC;
         end
         S_VEC_PC: if (ready) begin
            load_pc = 1'b1;
            next_state = S_IFETCH;
         end
         S_IFETCH: if (ready) begin
            load_ir = 1'b1;
            inc_pc = 1'b1;
            next_state = S_DECODE;
         end
         S_DECODE: begin
            if (is_dual)
               next_state = S_TS_READ;
            else if (is_jump)
               next_state = S_JUMP;
            else if (is_shift) begin
               shift_load = 1'b1;
               next_state = S_SHIFT_READ;
            end else if (is_imm)
               next_state = S_IMM_FETCH;
            else
               next_state = S_ILLEGAL;
         end
         S_ILLEGAL: next_state = S_IFETCH;
         S_IMM_FETCH: if (ready) begin
            load_operand = 1'b1;
            inc_pc = 1'b1;
            if (imm_op == IMM_OP_LI || imm_op == IMM_OP_LWPI)
               next_state = S_IMM_EXEC;  // No register read
            else
               next_state = S_IMM_READ;
         end
         S_IMM_READ: if (ready) begin
            load_result = 1'b1;
            next_state = S_IMM_EXEC;
         end
         S_IMM_EXEC: begin
            case (imm_op)
               IMM_OP_AI:   alu_op = ALU_ADD;
               IMM_OP_ANDI: alu_op = ALU_AND;
               IMM_OP_ORI:  alu_op = ALU_OR;
               IMM_OP_CI:   alu_op = ALU_CMP;
               default:     alu_op = ALU_PASS;
            endcase
            next_state = S_IFETCH;
            if (imm_op == IMM_OP_LWPI)
               load_wp = 1'b1;
            else begin
               load_st_flags = 1'b1;
               if (imm_op != IMM_OP_CI) begin
                  load_result = 1'b1;
                  next_state = S_IMM_WB;
               end
            end
         end
         S_JUMP: begin
            load_pc = take_jump;
            next_state = S_IFETCH;
         end
         S_TS_READ: if (ready) begin
            load_operand = 1'b1;
            next_state = S_TD_READ;
         end
         S_TD_READ: if (ready) begin
            load_result = 1'b1;
            next_state = S_DUAL_EXEC;
         end
         S_DUAL_EXEC: begin
            case (instr.fmt_dual.opcode)
               3'b010:  alu_op = ALU_ANDN;  // SZC
               3'b011:  alu_op = ALU_SUB;
               3'b100:  alu_op = ALU_CMP;
               3'b101:  alu_op = ALU_ADD;
               3'b111:  alu_op = ALU_OR;    // SOC
               default: alu_op = ALU_PASS;  // MOV
            endcase
            load_st_flags = 1'b1;
            load_result = (instr.fmt_dual.opcode != 3'b100);
            next_state = (instr.fmt_dual.opcode == 3'b100) ? S_IFETCH : S_DUAL_WB;
         end
         S_SHIFT_READ: if (ready) begin
            load_result = 1'b1;
            load_st_flags = (instr.fmt_shift.opcode[6:7] == 2'b10);  // SLA starts with OV clear
            next_state = S_SHIFT_STEP;
         end
         S_SHIFT_STEP: begin
            case (instr.fmt_shift.opcode[6:7])
               2'b00:   alu_op = ALU_SRA;
               2'b01:   alu_op = ALU_SRL;
               2'b10:   alu_op = ALU_SLA;
               default: alu_op = ALU_SRC;
            endcase
            shift_step = 1'b1;
            load_result = 1'b1;
            load_st_flags = 1'b1;
            if (shift_last)
               next_state = S_SHIFT_WB;
         end
         S_IMM_WB, S_DUAL_WB, S_SHIFT_WB: if (ready)
            next_state = S_IFETCH;
         default: next_state = S_RESET;
      endcase
   end

   // Address for the state being entered, so a is ready when memen rises
   always_comb begin
      case (next_state)
         S_VEC_WP: addr_sel = ADDR_VEC;
         S_VEC_PC: addr_sel = ADDR_VEC_NEXT;
         S_IMM_READ, S_IMM_WB, S_TS_READ, S_SHIFT_READ, S_SHIFT_WB: addr_sel = ADDR_WS_S;
         S_TD_READ, S_DUAL_WB: addr_sel = ADDR_WS_D;
         default: addr_sel = ADDR_PC;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= S_RESET;
      else
         state <= next_state;
   end

   assign memen = state inside {S_VEC_WP, S_VEC_PC, S_IFETCH, S_IMM_FETCH, S_IMM_READ,
                                S_IMM_WB, S_TS_READ, S_TD_READ, S_DUAL_WB, S_SHIFT_READ,
                                S_SHIFT_WB};
   assign we = state inside {S_IMM_WB, S_DUAL_WB, S_SHIFT_WB};
   assign iaq = (state == S_IFETCH);

endmodule

// File: hdl/tms9900_core.sv
`timescale 1ns/1ns

module tms9900_core import tms9900_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   output logic  memen,
   output logic  we,
   output logic  iaq,
   output logic  dbin,
   output addr_t a,
   output word_t q,
   input  word_t d_in,
   input  logic  ready,
   output word_t debug_pc,
   output word_t debug_st,
   output word_t debug_wp
);

   instr_u     instr;
   word_t      operand;
   word_t      alu_result;
   logic [0:4] alu_flags;
   logic [2:0] addr_sel;
   alu_op_t    alu_op;
   logic       load_ir;
   logic       load_pc;
   logic       inc_pc;
   logic       load_wp;
   logic       load_st_flags;
   logic       load_operand;
   logic       load_result;
   logic       shift_load;
   logic       shift_step;
   logic       shift_last;

   tms9900_control u_control (
      .clk(clk), .reset(reset), .ready(ready), .instr(instr), .st(debug_st),
      .shift_last(shift_last), .memen(memen), .we(we), .iaq(iaq), .addr_sel(addr_sel),
      .alu_op(alu_op), .load_ir(load_ir), .load_pc(load_pc), .inc_pc(inc_pc),
      .load_wp(load_wp), .load_st_flags(load_st_flags), .load_operand(load_operand),
      .load_result(load_result), .shift_load(shift_load), .shift_step(shift_step)
   );

   tms9900_regs u_regs (
      .clk(clk), .reset(reset), .d_in(d_in), .alu_result(alu_result),
      .alu_flags(alu_flags), .memen(memen), .we(we), .load_ir(load_ir),
      .load_pc(load_pc), .inc_pc(inc_pc), .load_wp(load_wp),
      .load_st_flags(load_st_flags), .load_operand(load_operand),
      .load_result(load_result), .addr_sel(addr_sel), .a(a), .q(q), .dbin(dbin),
      .instr(instr), .operand(operand), .pc(debug_pc), .st(debug_st), .wp(debug_wp)
   );

   tms9900_alu u_alu (
      .alu_op(alu_op), .operand(operand), .result(q), .st(debug_st), .instr(instr),
      .alu_result(alu_result), .alu_flags(alu_flags)
   );

   tms9900_shift_counter u_shift_counter (
      .clk(clk), .reset(reset), .shift_load(shift_load),
      .count(instr.fmt_shift.count), .shift_step(shift_step), .shift_last(shift_last)
   );

endmodule

// File: test/tms9900_core_sva.sv
`timescale 1ns/1ns

module tms9900_core_sva (
   input logic        clk,
   input logic        reset,
   input logic        memen,
   input logic        we,
   input logic        iaq,
   input logic        ready,
   input logic [14:0] a
);

   int fail_count = 0;  // Assertion failures so far

   // Address and direction hold while the bus waits
   assert property (@(posedge clk) disable iff (reset)
      (memen && !ready) |=> ($stable(a) && $stable(we)))
      else begin
         $error("a or we changed during a wait state");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (reset) !(iaq && we))
      else begin
         $error("iaq and we high together");
         fail_count++;
      end

   assert property (@(posedge clk) reset |=> !memen)
      else begin
         $error("memen high after reset");
         fail_count++;
      end

endmodule

// File: test/tms9900_checker.sv
`timescale 1ns/1ns

module tms9900_checker import tms9900_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  memen,
   input  logic  we,
   input  logic  iaq,
   input  logic  dbin,
   input  logic  ready,
   input  addr_t a,
   input  word_t q,
   input  word_t debug_pc,
   input  word_t debug_st,
   input  word_t debug_wp,
   output int    error_count,
   output logic  done
);

   logic [15:0] model_mem [0:32767];  // Filled by the testbench
   logic [15:0] pc;
   logic [15:0] wp;
   logic [0:4]  st;
   logic [14:0] exp_addr [$];
   logic [15:0] exp_data [$];
   int          vec_reads;
   logic        fetched;
   logic [14:0] last_iaq;

   function automatic logic [14:0] reg_addr(input logic [3:0] r);
      return wp[15:1] + 15'(r);
   endfunction

   task automatic check_value(input string name, input logic [15:0] expv,
                              input logic [15:0] actv);
      if (actv !== expv) begin
         $display("[FAIL] t=%0t %s: expected %h, actual %h", $time, name, expv, actv);
         error_count++;
      end
   endtask

   task automatic log_failure(input string msg);
      $display("Error at t=%0t: %s", $time, msg);
      error_count++;
   endtask

   task automatic flags_from_result(input logic [15:0] r);
      st[ST_LGT] = (r != 0);
      st[ST_AGT] = !r[15] && (r != 0);
      st[ST_EQ]  = (r == 0);
   endtask

   task automatic flags_from_compare(input logic [15:0] x, input logic [15:0] y);
      st[ST_LGT] = (x > y);
      st[ST_AGT] = ($signed(x) > $signed(y));
      st[ST_EQ]  = (x == y);
   endtask

   task automatic write_reg(input logic [3:0] r, input logic [15:0] v);
      model_mem[reg_addr(r)] = v;
      exp_addr.push_back(reg_addr(r));
      exp_data.push_back(v);
   endtask

   function automatic logic jump_taken(input logic [3:0] cond);
      case (cond)
         4'd0:    return 1'b1;
         4'd1:    return !st[ST_AGT] && !st[ST_EQ];
         4'd2:    return !st[ST_LGT] || st[ST_EQ];
         4'd3:    return st[ST_EQ];
         4'd4:    return st[ST_LGT] || st[ST_EQ];
         4'd5:    return st[ST_AGT];
         4'd6:    return !st[ST_EQ];
         4'd7:    return !st[ST_C];
         4'd8:    return st[ST_C];
         4'd9:    return !st[ST_OV];
         4'd10:   return !st[ST_LGT] && !st[ST_EQ];
         default: return st[ST_LGT] && !st[ST_EQ];
      endcase
   endfunction

   // Adds or subtracts x and y with TMS9900 carry and overflow
   task automatic arith(input logic [15:0] x, input logic [15:0] y, input logic subtract,
                        output logic [15:0] r);
      logic [16:0] sum;
      sum = subtract ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});
      r = sum[15:0];
      st[ST_C] = subtract ? (x >= y) : sum[16];
      st[ST_OV] = subtract ? (x[15] != y[15]) && (r[15] != x[15])
                           : (x[15] == y[15]) && (r[15] != x[15]);
      flags_from_result(r);
   endtask

   task automatic execute;
      logic [15:0] ir;
      logic [15:0] s;
      logic [15:0] dv;
      logic [15:0] r;
      int          n;
      ir = model_mem[pc[15:1]];
      pc = pc + 16'd2;
      if (ir[15:13] >= 3'd2 && ir[12:10] == 3'b000 && ir[5:4] == 2'b00) begin
         s = model_mem[reg_addr(ir[3:0])];
         dv = model_mem[reg_addr(ir[9:6])];
         case (ir[15:13])
            3'd2: r = dv & ~s;  // SZC
            3'd3: arith(dv, s, 1'b1, r);
            3'd5: arith(dv, s, 1'b0, r);
            3'd6: r = s;
            default: r = dv | s;
         endcase
         if (ir[15:13] == 3'd4)
            flags_from_compare(s, dv);
         else begin
            if (ir[15:13] inside {3'd2, 3'd6, 3'd7})
               flags_from_result(r);
            write_reg(ir[9:6], r);
         end
      end else if (ir[15:12] == 4'h1 && ir[11:8] <= 4'd11) begin
         if (jump_taken(ir[11:8]))
            pc = pc + {{7{ir[7]}}, ir[7:0], 1'b0};
      end else if (ir[15:10] == 6'b000010) begin
         n = (ir[7:4] == 0) ? 16 : int'(ir[7:4]);
         r = model_mem[reg_addr(ir[3:0])];
         if (ir[9:8] == 2'b10)
            st[ST_OV] = 1'b0;
         repeat (n) begin
            case (ir[9:8])
               2'b00: begin
                  st[ST_C] = r[0];
                  r = {r[15], r[15:1]};
               end
               2'b01: begin
                  st[ST_C] = r[0];
                  r = r >> 1;
               end
               2'b10: begin
                  st[ST_C] = r[15];
                  if (r[15] != r[14])
                     st[ST_OV] = 1'b1;  // Sign changed
                  r = r << 1;
               end
               default: begin
                  st[ST_C] = r[0];
                  r = {r[0], r[15:1]};
               end
            endcase
         end
         flags_from_result(r);
         write_reg(ir[3:0], r);
      end else if (ir[15:8] == 8'h02 && !ir[4] && ir[7:5] != 3'd5 && ir[7:5] != 3'd6) begin
         s = model_mem[pc[15:1]];  // Immediate word
         pc = pc + 16'd2;
         dv = model_mem[reg_addr(ir[3:0])];
         case (ir[7:5])
            3'd0: begin
               flags_from_result(s);
               write_reg(ir[3:0], s);
            end
            3'd1: begin
               arith(dv, s, 1'b0, r);
               write_reg(ir[3:0], r);
            end
            3'd2: begin
               flags_from_result(dv & s);
               write_reg(ir[3:0], dv & s);
            end
            3'd3: begin
               flags_from_result(dv | s);
               write_reg(ir[3:0], dv | s);
            end
            3'd4: flags_from_compare(dv, s);
            default: wp = s;  // LWPI
         endcase
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         error_count = 0;
         done = 1'b0;
         vec_reads = 0;
         fetched = 1'b0;
         st = '0;
      end else begin
         if (!memen)
            check_value("dbin", 16'd0, {15'd0, dbin});
         if (memen && ready) begin
            if (vec_reads < 2) begin
               if (iaq || we)
                  log_failure("vector read marked as fetch or write");
               check_value("a", 16'(vec_reads), {1'b0, a});
               check_value("dbin", 16'd1, {15'd0, dbin});
               vec_reads++;
               wp = model_mem[0];
               pc = model_mem[1];
            end else if (iaq) begin
               if (exp_addr.size() != 0) begin
                  log_failure("instruction ended without its register write");
                  exp_addr.delete();
                  exp_data.delete();
               end
               check_value("a", {1'b0, pc[15:1]}, {1'b0, a});
               check_value("dbin", 16'd1, {15'd0, dbin});
               check_value("debug_pc", pc, debug_pc);
               check_value("debug_wp", wp, debug_wp);
               check_value("debug_st", {11'd0, st}, {11'd0, debug_st[0:4]});
               if (fetched && a == last_iaq)
                  done = 1'b1;
               fetched = 1'b1;
               last_iaq = a;
               execute();
            end else if (we) begin
               check_value("dbin", 16'd0, {15'd0, dbin});
               if (exp_addr.size() == 0)
                  log_failure("write where the model expects none");
               else begin
                  check_value("a", {1'b0, exp_addr.pop_front()}, {1'b0, a});
                  check_value("q", exp_data.pop_front(), q);
               end
            end else
               check_value("dbin", 16'd1, {15'd0, dbin});  // Operand read
         end
      end
   end

endmodule

// File: test/tb_tms9900_core.sv
`timescale 1ns/1ns

module tb_tms9900_core import tms9900_pkg::*; ();

   localparam int NUM_INSTR      = 200;
   localparam int CLK_PERIOD     = 10;
   localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 10;

   logic        clk;
   logic        reset;
   logic        ready;
   logic        memen;
   logic        we;
   logic        iaq;
   logic        dbin;
   addr_t       a;
   word_t       q;
   word_t       d_in;
   word_t       debug_pc;
   word_t       debug_st;
   word_t       debug_wp;
   int          error_count;
   logic        done;
   integer      seed = 22389;
   int          waits = 0;
   int          prog_addr;
   logic [15:0] mem [0:32767];

   tms9900_core u_dut (
      .clk(clk), .reset(reset), .memen(memen), .we(we), .iaq(iaq), .dbin(dbin), .a(a),
      .q(q), .d_in(d_in), .ready(ready), .debug_pc(debug_pc), .debug_st(debug_st),
      .debug_wp(debug_wp)
   );

   tms9900_checker u_checker (
      .clk(clk), .reset(reset), .memen(memen), .we(we), .iaq(iaq), .dbin(dbin),
      .ready(ready), .a(a), .q(q), .debug_pc(debug_pc), .debug_st(debug_st),
      .debug_wp(debug_wp), .error_count(error_count), .done(done)
   );

   bind tms9900_core tms9900_core_sva u_sva (
      .clk(clk), .reset(reset), .memen(memen), .we(we), .iaq(iaq), .ready(ready), .a(a)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   assign d_in = mem[a];

   always @(posedge clk) begin
      if (memen && we && ready)
         mem[a] <= q;
   end

   // Fresh 0 to 3 wait cycles for every bus cycle
   always @(posedge clk) begin
      if (memen && ready)
         waits = $unsigned($random(seed)) % 4;
      else if (memen && waits != 0)
         waits = waits - 1;
      #1;
      ready <= (waits == 0);
   end

   task automatic put_word(input int addr, input logic [15:0] w);
      mem[addr] = w;
      u_checker.model_mem[addr] = w;
   endtask

   // Places w at the next program word
   task automatic append_word(input logic [15:0] w);
      put_word(prog_addr, w);
      prog_addr++;
   endtask

   // Keeps immediates from reading as jumps or LWPI if a jump lands on them
   function automatic logic [15:0] random_imm();
      logic [15:0] v;
      v = 16'($random(seed));
      if (v[15:12] == 4'h1 || v[15:4] == 12'h02E)
         v[15] = ~v[15];
      return v;
   endfunction

   task automatic build_program;
      int          kind;
      logic [2:0]  sub;
      logic [15:0] w;
      for (int i = 0; i < 32768; i++)
         put_word(i, 16'(i * 40503) ^ 16'h5A3C);
      put_word(0, 16'h0100);
      put_word(1, 16'h0200);
      prog_addr = 16'h0100;
      for (int n = 0; n < NUM_INSTR; n++) begin
         w = 16'($random(seed));
         kind = $unsigned($random(seed)) % 16;
         if (kind == 0)
            append_word(16'h0000);
         else if (kind < 5)
            append_word({3'd2 + 3'($unsigned($random(seed)) % 6), 3'b000, w[9:6],
                         2'b00, w[3:0]});
         else if (kind < 8) begin
            case ($unsigned($random(seed)) % 6)
               0: sub = 3'd0;
               1: sub = 3'd1;
               2: sub = 3'd2;
               3: sub = 3'd3;
               4: sub = 3'd4;
               default: sub = 3'd7;
            endcase
            append_word({8'h02, sub, 1'b0, w[3:0]});
            if (sub == 3'd7)
               append_word((w[5:4] == 0) ? 16'h1000 : (w[5] ? 16'h2000 : 16'h0100));
            else
               append_word(random_imm());
         end else if (kind < 11)
            append_word({4'h1, 4'($unsigned($random(seed)) % 12), 6'd0, w[1:0]});
         else
            append_word({6'b000010, w[9:8], w[7:4], w[3:0]});
      end
      repeat (4)
         append_word(16'h10FF);  // Jump to self ends the program
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      ready = 1'b1;
      build_program();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      wait (done === 1'b1);
      repeat (2) @(posedge clk);
      $display("Run complete: %0d checker errors, %0d assertion failures", error_count,
               u_dut.u_sva.fail_count);
      if (error_count == 0 && u_dut.u_sva.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: program did not reach its final jump in %0d cycles, %0d errors",
               TIMEOUT_CYCLES, error_count);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: tms9900_core.f
hdl/tms9900_pkg.sv
hdl/tms9900_alu.sv
hdl/tms9900_shift_counter.sv
hdl/tms9900_regs.sv
hdl/tms9900_control.sv
hdl/tms9900_core.sv
test/tms9900_core_sva.sv
test/tms9900_checker.sv
test/tb_tms9900_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tms9900_core
FILELIST  ?= tms9900_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
